//--- src/axiPkg.sv
package axiPkg;

    parameter int dataBits = 32;
    parameter int addrBits = 32;
    parameter int idBits   = 4;    // ID as a master issues it.
    parameter int idsBits  = 8;    // ID as a slave sees it, widened by the master tag.
    parameter int lenBits  = 4;    // A burst carries ARLEN+1 beats.

    // The one-hot master tag sits just above the master ID in the slave-side ID.
    parameter int tagLo   = 4;
    parameter int tagHi   = 5;
    parameter int tagBits = tagHi - tagLo + 1;

    parameter logic [tagBits-1:0] tagM0 = 2'b01;
    parameter logic [tagBits-1:0] tagM1 = 2'b10;

    typedef enum logic [1:0] {
        okay   = 2'd0,
        slvErr = 2'd2,
        decErr = 2'd3
    } respType;

endpackage

//--- src/busMapPkg.sv
package busMapPkg;

    // Each slave owns one aligned region; anything else decodes to the default slave.
    parameter logic [31:0] s0Base     = 32'h0000_0000;
    parameter logic [31:0] s1Base     = 32'h0001_0000;
    parameter logic [31:0] regionSize = 32'h0001_0000;

    typedef enum logic [1:0] {
        tgtS0,
        tgtS1,
        tgtDefault
    } targetType;

endpackage

//--- src/readAddrRouter.sv
`timescale 1ns/1ps

module readAddrRouter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [axiPkg::addrBits-1:0] m0ArAddr,
    input  logic [axiPkg::idBits-1:0]   m0ArId,
    input  logic [axiPkg::lenBits-1:0]  m0ArLen,
    input  logic                        m0ArValid,
    output logic                        m0ArReady,
    input  logic [axiPkg::addrBits-1:0] m1ArAddr,
    input  logic [axiPkg::idBits-1:0]   m1ArId,
    input  logic [axiPkg::lenBits-1:0]  m1ArLen,
    input  logic                        m1ArValid,
    output logic                        m1ArReady,
    output logic [axiPkg::addrBits-1:0] s0ArAddr,
    output logic [axiPkg::idsBits-1:0]  s0ArId,
    output logic [axiPkg::lenBits-1:0]  s0ArLen,
    output logic                        s0ArValid,
    input  logic                        s0ArReady,
    output logic [axiPkg::addrBits-1:0] s1ArAddr,
    output logic [axiPkg::idsBits-1:0]  s1ArId,
    output logic [axiPkg::lenBits-1:0]  s1ArLen,
    output logic                        s1ArValid,
    input  logic                        s1ArReady,
    output logic [axiPkg::addrBits-1:0] sdArAddr,
    output logic [axiPkg::idsBits-1:0]  sdArId,
    output logic [axiPkg::lenBits-1:0]  sdArLen,
    output logic                        sdArValid,
    input  logic                        sdArReady
);
    import axiPkg::*;
    import busMapPkg::*;

    typedef enum logic [1:0] {
        arIdle,
        arGrantM0,
        arGrantM1
    } arStateType;

    arStateType          state;
    logic                lastM1;    // M1 held the most recent grant.
    logic [addrBits-1:0] addr;
    logic [idBits-1:0]   id;
    logic [lenBits-1:0]  len;
    logic [tagBits-1:0]  tag;
    logic                valid;
    logic                ready;
    logic [idsBits-1:0]  idOut;
    targetType           target;

    // With both masters waiting, the one not served last gets the grant.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state  <= arIdle;
            lastM1 <= 1'b0;
        end else begin
            case (state)
                arIdle: begin
                    if (m0ArValid && (!m1ArValid || lastM1)) begin
                        state  <= arGrantM0;
                        lastM1 <= 1'b0;
                    end else if (m1ArValid) begin
                        state  <= arGrantM1;
                        lastM1 <= 1'b1;
                    end
                end
                default: begin
                    if (valid && ready)
                        state <= arIdle;
                end
            endcase
        end
    end

    always_comb begin
        case (state)
            arGrantM0: begin
                addr  = m0ArAddr;
                id    = m0ArId;
                len   = m0ArLen;
                valid = m0ArValid;
                tag   = tagM0;
            end
            arGrantM1: begin
                addr  = m1ArAddr;
                id    = m1ArId;
                len   = m1ArLen;
                valid = m1ArValid;
                tag   = tagM1;
            end
            default: begin
                addr  = '0;
                id    = '0;
                len   = '0;
                valid = 1'b0;
                tag   = '0;
            end
        endcase
    end

    always_comb begin
        if ((addr - s0Base) < regionSize)
            target = tgtS0;
        else if ((addr - s1Base) < regionSize)
            target = tgtS1;
        else
            target = tgtDefault;
    end

    always_comb begin
        idOut = '0;
        idOut[idBits-1:0] = id;
        idOut[tagHi:tagLo] = tag;    // The R side steers the reply back by this tag.
    end

    always_comb begin
        case (target)
            tgtS0:   ready = s0ArReady;
            tgtS1:   ready = s1ArReady;
            default: ready = sdArReady;
        endcase
    end

    assign s0ArAddr  = addr;
    assign s1ArAddr  = addr;
    assign sdArAddr  = addr;
    assign s0ArId    = idOut;
    assign s1ArId    = idOut;
    assign sdArId    = idOut;
    assign s0ArLen   = len;
    assign s1ArLen   = len;
    assign sdArLen   = len;
    assign s0ArValid = valid && (target == tgtS0);
    assign s1ArValid = valid && (target == tgtS1);
    assign sdArValid = valid && (target == tgtDefault);

    assign m0ArReady = (state == arGrantM0) && ready;
    assign m1ArReady = (state == arGrantM1) && ready;

    assert property (@(posedge clk) disable iff (!rst)
        $onehot0({s0ArValid, s1ArValid, sdArValid}))
        else $error("More than one slave sees an AR request.");

    // Once offered, an AR request holds its payload until the chosen slave takes it.
    assert property (@(posedge clk) disable iff (!rst)
        (valid && !ready) |=> (valid && $stable(addr) && $stable(idOut) && $stable(len)))
        else $error("AR request changed before its handshake.");

endmodule

//--- src/readDataRouter.sv
`timescale 1ns/1ps

module readDataRouter #(
    parameter int dataWidth = axiPkg::dataBits
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [axiPkg::idsBits-1:0] s0RId,
    input  logic [dataWidth-1:0]       s0RData,
    input  axiPkg::respType            s0RResp,
    input  logic                       s0RLast,
    input  logic                       s0RValid,
    output logic                       s0RReady,
    input  logic [axiPkg::idsBits-1:0] s1RId,
    input  logic [dataWidth-1:0]       s1RData,
    input  axiPkg::respType            s1RResp,
    input  logic                       s1RLast,
    input  logic                       s1RValid,
    output logic                       s1RReady,
    input  logic [axiPkg::idsBits-1:0] sdRId,
    input  logic [dataWidth-1:0]       sdRData,
    input  axiPkg::respType            sdRResp,
    input  logic                       sdRLast,
    input  logic                       sdRValid,
    output logic                       sdRReady,
    output logic [axiPkg::idBits-1:0]  m0RId,
    output logic [dataWidth-1:0]       m0RData,
    output axiPkg::respType            m0RResp,
    output logic                       m0RLast,
    output logic                       m0RValid,
    input  logic                       m0RReady,
    output logic [axiPkg::idBits-1:0]  m1RId,
    output logic [dataWidth-1:0]       m1RData,
    output axiPkg::respType            m1RResp,
    output logic                       m1RLast,
    output logic                       m1RValid,
    input  logic                       m1RReady
);
    import axiPkg::*;

    typedef enum logic [1:0] {
        selNone,
        selS0,
        selS1,
        selSd
    } selType;

    selType               sel;
    logic                 lockS0, lockS1, lockSd;
    logic [idsBits-1:0]   rId;
    logic [dataWidth-1:0] rData;
    respType              rResp;
    logic                 rLast;
    logic                 rValid;
    logic                 readyM;

    // A lock keeps the burst's slave connected from its first beat to its accepted RLAST.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lockS0 <= 1'b0;
            lockS1 <= 1'b0;
            lockSd <= 1'b0;
        end else begin
            lockS0 <= (s0RReady && s0RLast) ? 1'b0 : (sel == selS0 && s0RValid) ? 1'b1 : lockS0;
            lockS1 <= (s1RReady && s1RLast) ? 1'b0 : (sel == selS1 && s1RValid) ? 1'b1 : lockS1;
            lockSd <= (sdRReady && sdRLast) ? 1'b0 : (sel == selSd && sdRValid) ? 1'b1 : lockSd;
        end
    end

    // Fixed priority default > S1 > S0 when no burst is in flight.
    always_comb begin
        if (lockSd || (sdRValid && !lockS0 && !lockS1))
            sel = selSd;
        else if (lockS1 || (s1RValid && !lockS0))
            sel = selS1;
        else if (lockS0 || s0RValid)
            sel = selS0;
        else
            sel = selNone;
    end

    always_comb begin
        case (sel)
            selS0: begin
                rId    = s0RId;
                rData  = s0RData;
                rResp  = s0RResp;
                rLast  = s0RLast;
                rValid = s0RValid;
            end
            selS1: begin
                rId    = s1RId;
                rData  = s1RData;
                rResp  = s1RResp;
                rLast  = s1RLast;
                rValid = s1RValid;
            end
            selSd: begin
                rId    = sdRId;
                rData  = sdRData;
                rResp  = sdRResp;
                rLast  = sdRLast;
                rValid = sdRValid;
            end
            default: begin
                rId    = '0;
                rData  = '0;
                rResp  = okay;
                rLast  = 1'b0;
                rValid = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (rId[tagHi:tagLo])
            tagM0:   readyM = m0RReady;
            tagM1:   readyM = m1RReady;
            default: readyM = 1'b1;    // A beat with no valid tag is drained.
        endcase
    end

    assign s0RReady = (sel == selS0) && s0RValid && readyM;
    assign s1RReady = (sel == selS1) && s1RValid && readyM;
    assign sdRReady = (sel == selSd) && sdRValid && readyM;

    assign m0RId    = rId[idBits-1:0];
    assign m0RData  = rData;
    assign m0RResp  = rResp;
    assign m0RLast  = rLast;
    assign m0RValid = rValid && (rId[tagHi:tagLo] == tagM0);
    assign m1RId    = rId[idBits-1:0];
    assign m1RData  = rData;
    assign m1RResp  = rResp;
    assign m1RLast  = rLast;
    assign m1RValid = rValid && (rId[tagHi:tagLo] == tagM1);

    assert property (@(posedge clk) disable iff (!rst)
        $onehot0({lockS0, lockS1, lockSd}))
        else $error("More than one R burst lock is set.");

    // Until its RLAST beat is accepted, a presenting slave keeps the channel.
    assert property (@(posedge clk) disable iff (!rst)
        (rValid && !(readyM && rLast)) |=> (sel == $past(sel)))
        else $error("R channel switched slaves inside a burst.");

endmodule

//--- src/defaultSlave.sv
`timescale 1ns/1ps

module defaultSlave #(
    parameter int dataWidth = axiPkg::dataBits
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [axiPkg::idsBits-1:0] sdArId,
    input  logic [axiPkg::lenBits-1:0] sdArLen,
    input  logic                       sdArValid,
    output logic                       sdArReady,
    output logic [axiPkg::idsBits-1:0] sdRId,
    output logic [dataWidth-1:0]       sdRData,
    output axiPkg::respType            sdRResp,
    output logic                       sdRLast,
    output logic                       sdRValid,
    input  logic                       sdRReady
);
    import axiPkg::*;

    typedef enum logic {
        dsIdle,
        dsBurst
    } dsStateType;

    dsStateType         state;
    logic [idsBits-1:0] idReg;
    logic [lenBits-1:0] beatsLeft;    // Beats still owed after the current one.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= dsIdle;
            beatsLeft <= '0;
        end else begin
            case (state)
                dsIdle: begin
                    if (sdArValid) begin
                        state     <= dsBurst;
                        beatsLeft <= sdArLen;
                    end
                end
                default: begin
                    if (sdRReady) begin
                        if (beatsLeft == '0)
                            state <= dsIdle;
                        else
                            beatsLeft <= beatsLeft - 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sdArValid && sdArReady)
            idReg <= sdArId;
    end

    assign sdArReady = (state == dsIdle);
    assign sdRValid  = (state == dsBurst);
    assign sdRLast   = (state == dsBurst) && (beatsLeft == '0);
    assign sdRId     = idReg;
    assign sdRData   = '0;
    assign sdRResp   = decErr;

    // A request that arrives during a burst waits, unchanged, until the slave is idle.
    assert property (@(posedge clk) disable iff (!rst)
        (sdArValid && !sdArReady) |=> (sdArValid && $stable(sdArId) && $stable(sdArLen)))
        else $error("AR request to the default slave changed before it was accepted.");

endmodule

//--- src/readCrossbar.sv
`timescale 1ns/1ps

module readCrossbar #(
    parameter int dataWidth = axiPkg::dataBits
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [axiPkg::addrBits-1:0] m0ArAddr,
    input  logic [axiPkg::idBits-1:0]   m0ArId,
    input  logic [axiPkg::lenBits-1:0]  m0ArLen,
    input  logic                        m0ArValid,
    output logic                        m0ArReady,
    output logic [axiPkg::idBits-1:0]   m0RId,
    output logic [dataWidth-1:0]        m0RData,
    output axiPkg::respType             m0RResp,
    output logic                        m0RLast,
    output logic                        m0RValid,
    input  logic                        m0RReady,
    input  logic [axiPkg::addrBits-1:0] m1ArAddr,
    input  logic [axiPkg::idBits-1:0]   m1ArId,
    input  logic [axiPkg::lenBits-1:0]  m1ArLen,
    input  logic                        m1ArValid,
    output logic                        m1ArReady,
    output logic [axiPkg::idBits-1:0]   m1RId,
    output logic [dataWidth-1:0]        m1RData,
    output axiPkg::respType             m1RResp,
    output logic                        m1RLast,
    output logic                        m1RValid,
    input  logic                        m1RReady,
    output logic [axiPkg::addrBits-1:0] s0ArAddr,
    output logic [axiPkg::idsBits-1:0]  s0ArId,
    output logic [axiPkg::lenBits-1:0]  s0ArLen,
    output logic                        s0ArValid,
    input  logic                        s0ArReady,
    input  logic [axiPkg::idsBits-1:0]  s0RId,
    input  logic [dataWidth-1:0]        s0RData,
    input  axiPkg::respType             s0RResp,
    input  logic                        s0RLast,
    input  logic                        s0RValid,
    output logic                        s0RReady,
    output logic [axiPkg::addrBits-1:0] s1ArAddr,
    output logic [axiPkg::idsBits-1:0]  s1ArId,
    output logic [axiPkg::lenBits-1:0]  s1ArLen,
    output logic                        s1ArValid,
    input  logic                        s1ArReady,
    input  logic [axiPkg::idsBits-1:0]  s1RId,
    input  logic [dataWidth-1:0]        s1RData,
    input  axiPkg::respType             s1RResp,
    input  logic                        s1RLast,
    input  logic                        s1RValid,
    output logic                        s1RReady
);
    import axiPkg::*;

    // Channel to the built-in default slave.
    logic [idsBits-1:0]   sdArId;
    logic [lenBits-1:0]   sdArLen;
    logic                 sdArValid;
    logic                 sdArReady;
    logic [idsBits-1:0]   sdRId;
    logic [dataWidth-1:0] sdRData;
    respType              sdRResp;
    logic                 sdRLast;
    logic                 sdRValid;
    logic                 sdRReady;

    readAddrRouter arRouter (
        .sdArAddr(),    // The default slave answers without looking at the address.
        .*
    );

    readDataRouter #(.dataWidth(dataWidth)) rRouter (.*);

    defaultSlave #(.dataWidth(dataWidth)) defSlave (.*);

endmodule

//--- tb/memSlaveModel.sv
`timescale 1ns/1ps

module memSlaveModel #(
    parameter logic [31:0] dataKey = 32'h0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [axiPkg::addrBits-1:0] arAddr,
    input  logic [axiPkg::idsBits-1:0]  arId,
    input  logic [axiPkg::lenBits-1:0]  arLen,
    input  logic                        arValid,
    output logic                        arReady,
    output logic [axiPkg::idsBits-1:0]  rId,
    output logic [axiPkg::dataBits-1:0] rData,
    output axiPkg::respType             rResp,
    output logic                        rLast,
    output logic                        rValid,
    input  logic                        rReady
);
    import axiPkg::*;

    logic [addrBits-1:0] qAddr[$];
    logic [idsBits-1:0]  qId[$];
    logic [lenBits-1:0]  qLen[$];
    logic [31:0]         lfsr = 32'hd7f6;

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit.
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    assign arReady = 1'b1;    // Requests queue up without limit.

    always @(negedge clk) begin
        if (rst && arValid && arReady) begin
            qAddr.push_back(arAddr);
            qId.push_back(arId);
            qLen.push_back(arLen);
        end
    end

    initial begin
        logic [addrBits-1:0] addr;
        logic [idsBits-1:0]  id;
        logic [lenBits-1:0]  len;
        rValid = 1'b0;
        rLast  = 1'b0;
        rId    = '0;
        rData  = '0;
        rResp  = okay;
        forever begin
            @(posedge clk);
            if (qAddr.size() != 0) begin
                addr = qAddr.pop_front();
                id   = qId.pop_front();
                len  = qLen.pop_front();
                repeat (randBits(2)) @(posedge clk);    // First beat 1 to 4 cycles later.
                for (int k = 0; k <= int'(len); k++) begin
                    #2;
                    rValid = 1'b1;
                    rId    = id;
                    rData  = (addr + 32'(4 * k)) ^ dataKey;
                    rLast  = (k == int'(len));
                    @(negedge clk);
                    while (!rReady) @(negedge clk);
                    @(posedge clk);
                    if (randBits(2) == 32'd0) begin
                        #2;
                        rValid = 1'b0;    // An idle cycle between beats now and then.
                        rLast  = 1'b0;
                        @(posedge clk);
                    end
                end
                #2;
                rValid = 1'b0;
                rLast  = 1'b0;
            end
        end
    end

endmodule

//--- tb/tbReadCrossbar.sv
`timescale 1ns/1ps

module tbReadCrossbar;
    import axiPkg::*;

    logic                 clk = 1'b0;
    logic                 rst;
    logic [31:0]          arAddr [2];
    logic [3:0]           arId [2];
    logic [3:0]           arLen [2];
    logic [1:0]           arValid;
    logic [1:0]           arReady;
    logic [1:0]           rReady;
    logic [1:0]           rValid;
    logic [1:0]           rLast;
    logic [3:0]           rId [2];
    logic [31:0]          rData [2];
    respType              rResp [2];
    logic [addrBits-1:0]  s0ArAddr, s1ArAddr;
    logic [idsBits-1:0]   s0ArId, s1ArId, s0RId, s1RId;
    logic [lenBits-1:0]   s0ArLen, s1ArLen;
    logic                 s0ArValid, s1ArValid, s0ArReady, s1ArReady;
    logic [dataBits-1:0]  s0RData, s1RData;
    respType              s0RResp, s1RResp;
    logic                 s0RLast, s1RLast, s0RValid, s1RValid, s0RReady, s1RReady;

    logic [31:0] lfsr = 32'hd7f6;
    logic        stallOn = 1'b0;
    int          cycles = 0;
    int          issuedTxns = 0;
    int          doneTxns = 0;
    int          issuedBeats = 0;
    logic [3:0]  nextId [2];
    logic [31:0] pendAddr [2][16];    // Outstanding reads per master, indexed by ID.
    logic [3:0]  pendLen [2][16];
    logic        pendBusy [2][16];
    logic        inBurst [2];
    logic [3:0]  curId [2];
    int          beatNo [2];

    readCrossbar uut (
        .m0ArAddr(arAddr[0]), .m0ArId(arId[0]), .m0ArLen(arLen[0]),
        .m0ArValid(arValid[0]), .m0ArReady(arReady[0]), .m0RId(rId[0]),
        .m0RData(rData[0]), .m0RResp(rResp[0]), .m0RLast(rLast[0]),
        .m0RValid(rValid[0]), .m0RReady(rReady[0]),
        .m1ArAddr(arAddr[1]), .m1ArId(arId[1]), .m1ArLen(arLen[1]),
        .m1ArValid(arValid[1]), .m1ArReady(arReady[1]), .m1RId(rId[1]),
        .m1RData(rData[1]), .m1RResp(rResp[1]), .m1RLast(rLast[1]),
        .m1RValid(rValid[1]), .m1RReady(rReady[1]),
        .*
    );

    memSlaveModel #(.dataKey(32'h5A5A_0000)) s0Model (
        .clk, .rst, .arAddr(s0ArAddr), .arId(s0ArId), .arLen(s0ArLen),
        .arValid(s0ArValid), .arReady(s0ArReady), .rId(s0RId), .rData(s0RData),
        .rResp(s0RResp), .rLast(s0RLast), .rValid(s0RValid), .rReady(s0RReady)
    );

    memSlaveModel #(.dataKey(32'hA5A5_0000)) s1Model (
        .clk, .rst, .arAddr(s1ArAddr), .arId(s1ArId), .arLen(s1ArLen),
        .arValid(s1ArValid), .arReady(s1ArReady), .rId(s1RId), .rData(s1RData),
        .rResp(s1RResp), .rLast(s1RLast), .rValid(s1RValid), .rReady(s1RReady)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Target 0 is S0, 1 is S1, anything else lands above the map.
    function automatic logic [31:0] randAddr(input int target);
        logic [31:0] r;
        r = randBits(14) << 2;
        case (target)
            0: return r;
            1: return r | 32'h0001_0000;
            default: return r | (randBits(15) << 17) | 32'h0002_0000;
        endcase
    endfunction

    // Expected response and data of beat k of a burst starting at addr.
    function automatic logic [33:0] expectBeat(input logic [31:0] addr, input int k);
        logic [31:0] word;
        word = addr + 32'(4 * k);
        if (addr < 32'h0001_0000)
            return {okay, word ^ 32'h5A5A_0000};
        else if (addr < 32'h0002_0000)
            return {okay, word ^ 32'hA5A5_0000};
        else
            return {decErr, 32'h0};
    endfunction

    task automatic stopWithFailure();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
            stopWithFailure();
        end
    endtask

    task automatic checkIdleOutputs();
        checkValue("m0RValid", rValid[0], 1'b0);
        checkValue("m1RValid", rValid[1], 1'b0);
        checkValue("m0ArReady", arReady[0], 1'b0);
        checkValue("m1ArReady", arReady[1], 1'b0);
    endtask

    // Called at 2 ns after a rising edge; returns at the same phase.
    task automatic issueRead(input int m, input logic [31:0] addr, input logic [3:0] len);
        logic [3:0] id;
        id = nextId[m];
        while (pendBusy[m][id]) begin
            @(posedge clk);
            #2;
        end
        nextId[m] = id + 4'd1;
        pendAddr[m][id] = addr;
        pendLen[m][id]  = len;
        pendBusy[m][id] = 1'b1;
        issuedTxns++;
        issuedBeats += int'(len) + 1;
        arAddr[m]  = addr;
        arId[m]    = id;
        arLen[m]   = len;
        arValid[m] = 1'b1;
        @(negedge clk);
        while (!arReady[m]) @(negedge clk);
        @(posedge clk);
        #2;
        arValid[m] = 1'b0;
    endtask

    task automatic waitIdle();
        while (doneTxns != issuedTxns) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic randomReads(input int m);
        for (int i = 0; i < 40; i++) begin
            issueRead(m, randAddr(int'(randBits(2) % 3)), 4'(randBits(4)));
            repeat (randBits(2)) begin
                @(posedge clk);
                #2;
            end
        end
    endtask

    task automatic acceptBeat(input int m, input logic [3:0] id, input logic [31:0] data,
                              input logic [1:0] resp, input logic last);
        logic [33:0] exp;
        if (!inBurst[m] && !pendBusy[m][id]) begin
            $display("Master %0d received a beat for ID %0d with no read outstanding.", m, id);
            stopWithFailure();
        end else begin
            if (!inBurst[m]) begin
                inBurst[m] = 1'b1;
                curId[m]   = id;
                beatNo[m]  = 0;
            end
            checkValue($sformatf("m%0dRId", m), id, curId[m]);    // No other burst in between.
            exp = expectBeat(pendAddr[m][curId[m]], beatNo[m]);
            checkValue($sformatf("m%0dRData", m), data, exp[31:0]);
            checkValue($sformatf("m%0dRResp", m), resp, exp[33:32]);
            checkValue($sformatf("m%0dRLast", m), last, beatNo[m] == int'(pendLen[m][curId[m]]));
            beatNo[m]++;
            if (last) begin
                pendBusy[m][curId[m]] = 1'b0;
                inBurst[m] = 1'b0;
                doneTxns++;
            end
        end
    endtask

    // Masters accept about three beats in four once stalls are on.
    always @(posedge clk) begin
        #2;
        rReady[0] = !stallOn || (randBits(2) != 32'd0);
        rReady[1] = !stallOn || (randBits(2) != 32'd0);
    end

    always @(negedge clk) begin
        if (rst && rValid[0] && rReady[0])
            acceptBeat(0, rId[0], rData[0], rResp[0], rLast[0]);
        if (rst && rValid[1] && rReady[1])
            acceptBeat(1, rId[1], rData[1], rResp[1], rLast[1]);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 200 + 64 * issuedBeats) begin
            $display("Timeout: reads still outstanding after %0d cycles.", cycles);
            stopWithFailure();
        end
    end

    initial begin
        rst     = 1'b0;
        arValid = 2'b00;
        rReady  = 2'b11;
        for (int m = 0; m < 2; m++) begin
            arAddr[m]  = '0;
            arId[m]    = '0;
            arLen[m]   = '0;
            nextId[m]  = '0;
            inBurst[m] = 1'b0;
            curId[m]   = '0;
            beatNo[m]  = 0;
            for (int i = 0; i < 16; i++)
                pendBusy[m][i] = 1'b0;
        end
        repeat (5) begin
            @(negedge clk);
            checkIdleOutputs();
        end
        @(posedge clk);
        #2;
        rst = 1'b1;
        @(negedge clk);
        checkIdleOutputs();
        @(posedge clk);
        #2;
        // Every length to S0 and S1, one master after the other.
        for (int m = 0; m < 2; m++) begin
            for (int len = 0; len < 16; len++) begin
                issueRead(m, randAddr(0), 4'(len));
                issueRead(m, randAddr(1), 4'(len));
            end
            waitIdle();
        end
        issueRead(0, 32'h0002_0000, 4'd3);
        for (int m = 0; m < 2; m++) begin
            issueRead(m, randAddr(2), 4'd0);
            issueRead(m, randAddr(2), 4'd15);
            issueRead(m, randAddr(2), 4'(randBits(4)));
        end
        waitIdle();
        stallOn = 1'b1;
        fork
            randomReads(0);
            randomReads(1);
        join
        waitIdle();
        repeat (20) @(negedge clk);    // A stray or repeated beat would still show up here.
        checkIdleOutputs();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- filelist.f
src/axiPkg.sv
src/busMapPkg.sv
src/readAddrRouter.sv
src/readDataRouter.sv
src/defaultSlave.sv
src/readCrossbar.sv
tb/memSlaveModel.sv
tb/tbReadCrossbar.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tbReadCrossbar \
    -f filelist.f -o simReadCrossbar \
    && ./obj_dir/simReadCrossbar \
    || exit 1
